// ==== design/latticePkg.sv ====
`default_nettype none

package latticePkg;

    localparam int nodeCount = 128;
    localparam int dimension = 7;   // One node per subset of dimension elements

    typedef logic [nodeCount - 1:0] graph_t;             // Bit i set when node i is present
    typedef logic [3:0] tag_t;
    typedef logic [$clog2(nodeCount + 1) - 1:0] count_t; // 0 to nodeCount

    typedef enum logic [1:0] {
        OpPruneUp,
        OpPruneDown,
        OpPruneBoth  // Upward pass first and then downward
    } pruneOp_e;

    typedef enum logic {
        DirUp,
        DirDown
    } pruneDir_e;

    typedef struct packed {
        pruneOp_e op;
        tag_t     tag;
        graph_t   graph;
    } pruneReq_t;

    // One request as it moves through the stages
    typedef struct packed {
        tag_t   tag;
        graph_t origGraph;  // Mask as accepted and kept for the changed flag
        graph_t graph;      // Mask after the stages so far
        logic   bypassUp;
        logic   bypassDown;
    } pruneBeat_t;

    typedef struct packed {
        tag_t   tag;
        graph_t graph;
        count_t count;
        logic   changed;
    } pruneRes_t;

endpackage

`default_nettype wire

// ==== design/pruneDecode.sv ====
`default_nettype none

module pruneDecode (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   inValid,
    input  latticePkg::pruneReq_t  inReq,
    input  logic                   advance,
    output logic                   decValid,
    output latticePkg::pruneBeat_t decBeat
);

    import latticePkg::*;

    pruneBeat_t nextBeat;

    // Each opcode turns off the pass it does not ask for
    always_comb begin
        nextBeat.tag        = inReq.tag;
        nextBeat.origGraph  = inReq.graph;
        nextBeat.graph      = inReq.graph;
        nextBeat.bypassUp   = (inReq.op == OpPruneDown);
        nextBeat.bypassDown = (inReq.op == OpPruneUp);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (advance) begin
            decValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            decBeat <= nextBeat;
        end
    end

endmodule

`default_nettype wire

// ==== design/leafPruneStage.sv ====
`default_nettype none

module leafPruneStage #(
    parameter latticePkg::pruneDir_e direction = latticePkg::DirUp
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   advance,
    input  logic                   beatValidIn,
    input  latticePkg::pruneBeat_t beatIn,
    output logic                   beatValidOut,
    output latticePkg::pruneBeat_t beatOut
);

    import latticePkg::*;

    graph_t graphIn;
    graph_t pruned;
    logic   bypass;

    assign graphIn = beatIn.graph;
    assign bypass  = (direction == DirUp) ? beatIn.bypassUp : beatIn.bypassDown;

    // Bottom and top of the lattice are never leaves
    assign pruned[0]             = graphIn[0];
    assign pruned[nodeCount - 1] = graphIn[nodeCount - 1];

    for (genvar node = 1; node < nodeCount - 1; node++) begin : gNode
        logic [dimension - 1:0] lowerBits;  // Neighbors with one element removed
        logic [dimension - 1:0] upperBits;  // Neighbors with one element added
        logic [dimension - 1:0] oneSide;
        logic [dimension - 1:0] otherSide;
        logic                   exactlyOne;

        for (genvar b = 0; b < dimension; b++) begin : gBit
            if (((node >> b) & 1) == 1) begin : gSet
                assign lowerBits[b] = graphIn[node & ~(1 << b)];
                assign upperBits[b] = 1'b0;
            end else begin : gClear
                assign lowerBits[b] = 1'b0;
                assign upperBits[b] = graphIn[node | (1 << b)];
            end
        end

        if (direction == DirUp) begin : gUp
            assign oneSide   = lowerBits;
            assign otherSide = upperBits;
        end else begin : gDown
            assign oneSide   = upperBits;
            assign otherSide = lowerBits;
        end

        // Nonzero with no second bit set
        assign exactlyOne = (oneSide != '0) && ((oneSide & (oneSide - 1'b1)) == '0);

        assign pruned[node] = graphIn[node] & ~(exactlyOne & ~(|otherSide));
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            beatValidOut <= 1'b0;
        end else if (advance) begin
            beatValidOut <= beatValidIn;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            beatOut       <= beatIn;
            beatOut.graph <= bypass ? graphIn : pruned;  // Bypassed beat still costs a cycle
        end
    end

endmodule

`default_nettype wire

// ==== design/pruneExecute.sv ====
`default_nettype none

module pruneExecute (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   advance,
    input  logic                   decValid,
    input  latticePkg::pruneBeat_t decBeat,
    output logic                   exeValid,
    output latticePkg::pruneBeat_t exeBeat
);

    import latticePkg::*;

    logic       upValid;
    pruneBeat_t upBeat;  // Between the two passes

    // Upward pass always runs before the downward one
    leafPruneStage #(
        .direction(DirUp)
    ) u_upStage (
        .clk          (clk),
        .rstN         (rstN),
        .advance      (advance),
        .beatValidIn  (decValid),
        .beatIn       (decBeat),
        .beatValidOut (upValid),
        .beatOut      (upBeat)
    );

    leafPruneStage #(
        .direction(DirDown)
    ) u_downStage (
        .clk          (clk),
        .rstN         (rstN),
        .advance      (advance),
        .beatValidIn  (upValid),
        .beatIn       (upBeat),
        .beatValidOut (exeValid),
        .beatOut      (exeBeat)
    );

endmodule

`default_nettype wire

// ==== design/pruneResult.sv ====
`default_nettype none

module pruneResult (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   exeValid,
    input  latticePkg::pruneBeat_t exeBeat,
    input  logic                   outReady,
    output logic                   outValid,
    output latticePkg::pruneRes_t  outRes,
    output logic                   advance
);

    import latticePkg::*;

    pruneRes_t nextRes;

    function automatic count_t popCount(input graph_t graph);
        count_t sum;
        sum = '0;
        for (int i = 0; i < nodeCount; i++) begin
            sum = sum + count_t'(graph[i]);
        end
        return sum;
    endfunction

    // Whole pipeline stalls while a result waits
    assign advance = !outValid || outReady;

    always_comb begin
        nextRes.tag     = exeBeat.tag;
        nextRes.graph   = exeBeat.graph;
        nextRes.count   = popCount(exeBeat.graph);
        nextRes.changed = (exeBeat.graph != exeBeat.origGraph);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (advance) begin
            outValid <= exeValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            outRes <= nextRes;  // Held while outReady is low
        end
    end

endmodule

`default_nettype wire

// ==== design/graphPruneTop.sv ====
`default_nettype none

module graphPruneTop (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inValid,
    output logic                  inReady,
    input  latticePkg::pruneReq_t inReq,
    output logic                  outValid,
    input  logic                  outReady,
    output latticePkg::pruneRes_t outRes
);

    import latticePkg::*;

    logic       advance;
    logic       decValid;
    pruneBeat_t decBeat;
    logic       exeValid;
    pruneBeat_t exeBeat;

    assign inReady = advance;

    pruneDecode u_pruneDecode (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReq    (inReq),
        .advance  (advance),
        .decValid (decValid),
        .decBeat  (decBeat)
    );

    pruneExecute u_pruneExecute (
        .clk      (clk),
        .rstN     (rstN),
        .advance  (advance),
        .decValid (decValid),
        .decBeat  (decBeat),
        .exeValid (exeValid),
        .exeBeat  (exeBeat)
    );

    pruneResult u_pruneResult (
        .clk      (clk),
        .rstN     (rstN),
        .exeValid (exeValid),
        .exeBeat  (exeBeat),
        .outReady (outReady),
        .outValid (outValid),
        .outRes   (outRes),
        .advance  (advance)
    );

endmodule

`default_nettype wire

// ==== dv/pruneModel.svh ====
`ifndef PRUNE_MODEL_SVH
`define PRUNE_MODEL_SVH

// One pass counting present neighbors below and above each inner node
function automatic graph_t prunePass(input graph_t g, input pruneDir_e dir);
    graph_t result;
    int     below;
    int     above;
    int     neighbor;
    result = g;
    for (int node = 1; node < nodeCount - 1; node++) begin
        below = 0;
        above = 0;
        for (int b = 0; b < dimension; b++) begin
            neighbor = node ^ (1 << b);
            if (g[neighbor]) begin
                if (neighbor < node) below++;  // One element removed
                else above++;
            end
        end
        if (g[node]) begin
            if (dir == DirUp && below == 1 && above == 0) result[node] = 1'b0;
            else if (dir == DirDown && above == 1 && below == 0) result[node] = 1'b0;
        end
    end
    return result;
endfunction

function automatic count_t countNodes(input graph_t g);
    int total;
    total = 0;
    for (int i = 0; i < nodeCount; i++) begin
        if (g[i]) total++;
    end
    return count_t'(total);
endfunction

function automatic pruneRes_t predictResult(input pruneReq_t req);
    pruneRes_t res;
    graph_t    g;
    g = req.graph;
    if (req.op != OpPruneDown) g = prunePass(g, DirUp);    // Upward pass comes first
    if (req.op != OpPruneUp) g = prunePass(g, DirDown);
    res.tag     = req.tag;
    res.graph   = g;
    res.count   = countNodes(g);
    res.changed = (g != req.graph);
    return res;
endfunction

`endif

// ==== dv/graphPruneTb.sv ====
`default_nettype none

module graphPruneTb;

    import latticePkg::*;

    localparam int transactions  = 300;
    localparam int timeoutCycles = transactions * 16 + 200;
    localparam int driveDelay    = 10;
    localparam graph_t endNodes  = {1'b1, {126{1'b0}}, 1'b1};  // Nodes 0 and 127

    typedef struct packed {
        pruneRes_t res;
        graph_t    origGraph;
    } expect_t;

    logic      clk;
    logic      rstN;
    logic      inValid;
    logic      inReady;
    pruneReq_t inReq;
    logic      outValid;
    logic      outReady;
    pruneRes_t outRes;

    logic [15:0] lfsr = 16'd37155;
    expect_t     expectQ[$];
    int          cycles;

    `include "pruneModel.svh"

    graphPruneTop u_graphPruneTop (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inReq    (inReq),
        .outValid (outValid),
        .outReady (outReady),
        .outRes   (outRes)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int width, output logic [127:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr  = lfsrStep(lfsr);
            value = {value[126:0], lfsr[0]};
        end
    endtask

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic reportError(input string msg);
        failRun($sformatf("error at time %0t: %s", $time, msg));
    endtask

    task automatic checkGraph(input graph_t actual, input graph_t expected, input string what);
        if (actual !== expected)
            reportError($sformatf("%s graph %h, expected %h", what, actual, expected));
    endtask

    task automatic checkCount(input count_t actual, input count_t expected, input string what);
        if (actual !== expected)
            reportError($sformatf("%s count %0d, expected %0d", what, actual, expected));
    endtask

    task automatic checkTag(input tag_t actual, input tag_t expected, input string what);
        if (actual !== expected)
            reportError($sformatf("%s tag %h, expected %h", what, actual, expected));
    endtask

    task automatic checkChanged(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            reportError($sformatf("%s changed %b, expected %b", what, actual, expected));
    endtask

    task automatic makeRequest(output pruneReq_t req);
        logic [127:0] bits;
        logic [127:0] second;
        logic [127:0] third;
        drawBits(2, bits);
        case (bits[1:0])
            2'd0:    req.op = OpPruneUp;
            2'd1:    req.op = OpPruneDown;
            default: req.op = OpPruneBoth;
        endcase
        drawBits(4, bits);
        req.tag = tag_t'(bits[3:0]);
        drawBits(3, bits);
        case (bits[2:0])
            3'd0: req.graph = '1;
            3'd1: req.graph = '0;
            3'd2, 3'd3: begin
                drawBits(128, bits);
                req.graph = bits;
            end
            3'd4, 3'd5: begin
                drawBits(128, bits);
                drawBits(128, second);
                req.graph = bits & second;  // Sparse so leaves are common
            end
            default: begin
                drawBits(128, bits);
                drawBits(128, second);
                drawBits(128, third);
                req.graph = bits & second & third;
            end
        endcase
    endtask

    initial begin
        cycles = 0;
        while (cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        failRun($sformatf("Timeout after %0d cycles with results still missing", cycles));
    end

    initial begin
        logic [127:0] bits;
        expect_t      exp;
        pruneRes_t    heldRes;
        logic         wasStalled;
        logic         pending;
        int           sent;
        int           received;

        rstN       = 1'b0;
        inValid    = 1'b0;
        inReq      = '0;
        outReady   = 1'b0;
        wasStalled = 1'b0;
        pending    = 1'b0;
        heldRes    = '0;
        sent       = 0;
        received   = 0;

        repeat (10) @(posedge clk);
        #driveDelay rstN = 1'b1;
        @(negedge clk);
        if (outValid !== 1'b0 || inReady !== 1'b1)
            reportError("outValid not low or inReady not high after reset");

        while (received < transactions) begin
            @(posedge clk);
            #driveDelay;
            drawBits(2, bits);
            outReady = (bits[1:0] != 2'd0);
            if (!pending) begin
                drawBits(2, bits);
                if (sent < transactions && bits[1:0] != 2'd0) begin
                    makeRequest(inReq);
                    inValid = 1'b1;
                    pending = 1'b1;
                end else begin
                    inValid = 1'b0;  // Gap with the source idle
                end
            end

            @(negedge clk);
            // A result stalled last cycle must still be there unchanged
            if (wasStalled) begin
                if (outValid !== 1'b1)
                    reportError("outValid dropped while outReady was low");
                checkTag(outRes.tag, heldRes.tag, "held");
                checkGraph(outRes.graph, heldRes.graph, "held");
                checkCount(outRes.count, heldRes.count, "held");
                checkChanged(outRes.changed, heldRes.changed, "held");
            end
            wasStalled = outValid && !outReady;
            heldRes    = outRes;

            if (outValid && outReady) begin
                if (expectQ.size() == 0)
                    failRun("A result came out with no request outstanding");
                exp = expectQ.pop_front();
                checkTag(outRes.tag, exp.res.tag, "result");
                checkGraph(outRes.graph & endNodes, exp.origGraph & endNodes, "end node");
                checkGraph(outRes.graph, exp.res.graph, "result");
                checkCount(outRes.count, exp.res.count, "result");
                checkChanged(outRes.changed, exp.res.changed, "result");
                received++;
            end

            if (inValid && inReady) begin
                exp.res       = predictResult(inReq);
                exp.origGraph = inReq.graph;
                expectQ.push_back(exp);
                sent++;
                pending = 1'b0;
            end
        end

        if (expectQ.size() != 0 || sent != transactions) begin
            failRun($sformatf("%0d expected results never came out", expectQ.size()));
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+dv
design/latticePkg.sv
design/pruneDecode.sv
design/leafPruneStage.sv
design/pruneExecute.sv
design/pruneResult.sv
design/graphPruneTop.sv
dv/graphPruneTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the graph pruning testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module graphPruneTb -f project.f -o graphPruneSim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/graphPruneSim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
